/* tb/lookup_input.dat */
# M port mac | R addr valid ip mask queue | I idle cycle
# P port dst_mac ethertype ver_ihl ttl dst_ip checksum action queue new_ttl new_checksum
M 0 020000000010
M 1 020000000011
M 2 020000000012
M 3 020000000013
# the /24 sits ahead of its /16
R 0 1 c0a80100 ffffff00 04
R 1 1 c0a80000 ffff0000 10
R 2 1 0a000000 ff000000 01
# forwarded
P 0 020000000010 0800 45 40 c0a80105 52b0 F 04 3f 53b0
P 1 020000000011 0800 45 40 c0a80205 51b0 F 10 3f 52b0
P 2 020000000012 0800 45 40 0a010203 085a F 01 3f 095a
# dropped, wrong MAC then bad checksum
P 0 020000000011 0800 45 40 c0a80105 52b0 D 00 3f 53b0
P 0 020000000010 0800 45 40 c0a80105 52b1 D 00 3f 53b1
# to the CPU: ARP, broadcast, options, TTL 1, TTL 0, no route
P 1 020000000011 0806 45 40 c0a80105 52b0 C 08 3f 53b0
P 2 ffffffffffff 0800 45 40 c0a80105 52b0 C 20 3f 53b0
P 3 020000000013 0800 46 40 c0a80105 51b0 C 80 3f 52b0
P 0 020000000010 0800 45 01 c0a80105 91b0 C 02 00 92b0
P 1 020000000011 0800 45 00 c0a80105 92b0 C 08 ff 93b0
P 2 020000000012 0800 45 40 ac100a01 5e4c C 20 3f 5f4c
I
# new /12 route, the same packet now forwards
R 3 1 ac100000 fff00000 40
P 2 020000000012 0800 45 40 ac100a01 5e4c F 40 3f 5f4c
# bad checksum near the top, new checksum wraps around
P 3 020000000013 0800 45 40 0a000001 ff80 D 00 3f 0081

/* output_port_lookup.f */
+incdir+rtl
rtl/net_hdr_pkg.sv
rtl/op_lut_pkg.sv
rtl/eth_classify.sv
rtl/ip_lpm.sv
rtl/ip_checksum_ttl.sv
rtl/op_lut_decide.sv
rtl/output_port_lookup.sv
tb/output_port_lookup_tb.sv

/* Makefile */
SRCS := $(shell grep '\.sv$$' output_port_lookup.f) rtl/op_lut_consts.svh
BIN  := obj_dir/Voutput_port_lookup_tb

.PHONY: all run clean

all: run

$(BIN): output_port_lookup.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module output_port_lookup_tb -f output_port_lookup.f

run: $(BIN) tb/lookup_input.dat
	./$(BIN) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/output_port_lookup_tb.sv */
`include "op_lut_consts.svh"

module output_port_lookup_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import net_hdr_pkg::*;
   import op_lut_pkg::*;

   localparam int        CLK_PERIOD = 20;
   localparam mac_addr_t SRC_MAC    = 48'h02aa_bbcc_ddee;
   localparam ip_addr_t  SRC_IP     = 32'h0a00_0001;

   // one expected result waiting for its out_wr
   typedef struct packed {
      decision_t dec;
      int        in_cycle;   // cycle count when in_wr was driven
      int        pkt_num;
   } expect_t;

   logic                                clk;
   logic                                reset;
   logic                                in_wr;
   pkt_hdr_t                            in_hdr;
   mac_addr_t [`OP_LUT_NUM_PORTS-1:0]   port_macs;
   logic                                route_wr;
   logic [`OP_LUT_ROUTE_ADDR_BITS-1:0]  route_addr;
   route_entry_t                        route_entry;
   logic                                out_wr;
   decision_t                           out_dec;

   string   lines[$];      // data lines without the comment lines
   expect_t exp_q[$];
   int      cycle = 0;
   int      pkt_count = 0;
   int      bad_lines = 0;
   int      pass_count = 0;
   int      fail_count = 0;
   int      stray_count = 0;
   bit      loaded = 1'b0;

   output_port_lookup uut (
      .clk         (clk),
      .reset       (reset),
      .in_wr       (in_wr),
      .in_hdr      (in_hdr),
      .port_macs   (port_macs),
      .route_wr    (route_wr),
      .route_addr  (route_addr),
      .route_entry (route_entry),
      .out_wr      (out_wr),
      .out_dec     (out_dec)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;   // counts rising edges

   //////////////////////////////////////////////////////////////////////
   // data file
   //////////////////////////////////////////////////////////////////////

   function automatic bit read_data_file();
      int    fd;
      string line;
      fd = $fopen("tb/lookup_input.dat", "r");
      if (fd == 0) begin
         return 1'b0;
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line.getc(0) != "#") begin
            lines.push_back(line);
         end
      end
      $fclose(fd);
      return 1'b1;
   endfunction

   function automatic action_e action_from_letter(logic [7:0] letter);
      case (letter)
         "F":     return FORWARD;
         "C":     return TO_CPU;
         default: return DROP;
      endcase
   endfunction

   // drives one data line for one cycle
   task automatic apply_line(input string line);
      logic [7:0]                         tag;
      logic [7:0]                         act;
      logic [`OP_LUT_PORT_BITS-1:0]       port;
      logic [`OP_LUT_ROUTE_ADDR_BITS-1:0] addr;
      logic                               valid;
      mac_addr_t                          mac;
      logic [15:0]                        etype;
      logic [7:0]                         ver_ihl;
      logic [7:0]                         ttl;
      ip_addr_t                           ip;
      ip_addr_t                           mask;
      logic [15:0]                        csum;
      logic [`OP_LUT_NUM_QUEUES-1:0]      queue;
      logic [7:0]                         new_ttl;
      logic [15:0]                        new_csum;
      pkt_hdr_t                           hdr;
      expect_t                            rec;
      int                                 n;
      int                                 want;
      in_wr    = 1'b0;
      route_wr = 1'b0;
      tag      = line.getc(0);
      n        = 0;
      want     = 0;
      case (tag)
         "M": begin
            want = 3;
            n    = $sscanf(line, "%c %h %h", tag, port, mac);
            port_macs[port] = mac;
         end
         "R": begin
            want = 6;
            n    = $sscanf(line, "%c %h %h %h %h %h", tag, addr, valid, ip, mask, queue);
            route_addr        = addr;
            route_entry.valid = valid;
            route_entry.ip    = ip;
            route_entry.mask  = mask;
            route_entry.queue = queue;
            route_wr          = 1'b1;
         end
         "P": begin
            want = 12;
            n    = $sscanf(line, "%c %h %h %h %h %h %h %h %c %h %h %h", tag, port, mac,
                           etype, ver_ihl, ttl, ip, csum, act, queue, new_ttl, new_csum);
            hdr               = '0;
            hdr.in_port       = port;
            hdr.eth.dst_mac   = mac;
            hdr.eth.src_mac   = SRC_MAC;
            hdr.eth.ethertype = ethertype_e'(etype);
            hdr.ip.version    = ver_ihl[7:4];
            hdr.ip.ihl        = ver_ihl[3:0];
            hdr.ip.length     = 16'h0054;
            hdr.ip.id         = 16'h1c46;
            hdr.ip.flags_frag = 16'h4000;   // don't fragment
            hdr.ip.ttl        = ttl;
            hdr.ip.protocol   = 8'h06;
            hdr.ip.checksum   = csum;
            hdr.ip.src_ip     = SRC_IP;
            hdr.ip.dst_ip     = ip;
            in_hdr            = hdr;
            in_wr             = 1'b1;
            pkt_count++;
            rec.dec.action       = action_from_letter(act);
            rec.dec.queue        = queue;
            rec.dec.in_port      = {1'b0, port};
            rec.dec.new_ttl      = new_ttl;
            rec.dec.new_checksum = new_csum;
            rec.in_cycle         = cycle;
            rec.pkt_num          = pkt_count;
            exp_q.push_back(rec);
         end
         "I": ;   // idle gap
         default: want = -1;
      endcase
      if (n != want) begin
         $display("data line not understood: %s", line);
         bad_lines++;
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // result checks
   //////////////////////////////////////////////////////////////////////

   task automatic check_result();
      expect_t rec;
      int      wrong;
      wrong = 0;
      assert (exp_q.size() != 0) else begin
         $display("out_wr pulsed at %0t with no packet in flight", $time);
         stray_count++;
      end
      if (exp_q.size() != 0) begin
         rec = exp_q.pop_front();
         assert (cycle - rec.in_cycle == `OP_LUT_LATENCY) else begin
            $display("Error at %0t: packet %0d came out after %0d cycles, expected %0d",
                     $time, rec.pkt_num, cycle - rec.in_cycle, `OP_LUT_LATENCY);
            wrong++;
         end
         assert (out_dec.action == rec.dec.action) else begin
            $display("Error at %0t: packet %0d action %0d, expected %0d",
                     $time, rec.pkt_num, out_dec.action, rec.dec.action);
            wrong++;
         end
         assert (out_dec.queue == rec.dec.queue) else begin
            $display("Error at %0t: packet %0d queue %h, expected %h",
                     $time, rec.pkt_num, out_dec.queue, rec.dec.queue);
            wrong++;
         end
         assert (out_dec.in_port == rec.dec.in_port) else begin
            $display("Error at %0t: packet %0d in_port %0d, expected %0d",
                     $time, rec.pkt_num, out_dec.in_port, rec.dec.in_port);
            wrong++;
         end
         assert (out_dec.new_ttl == rec.dec.new_ttl) else begin
            $display("Error at %0t: packet %0d new TTL %h, expected %h",
                     $time, rec.pkt_num, out_dec.new_ttl, rec.dec.new_ttl);
            wrong++;
         end
         assert (out_dec.new_checksum == rec.dec.new_checksum) else begin
            $display("Error at %0t: packet %0d new checksum %h, expected %h",
                     $time, rec.pkt_num, out_dec.new_checksum, rec.dec.new_checksum);
            wrong++;
         end
         if (wrong == 0) begin
            pass_count++;
            $display("packet %0d passed", rec.pkt_num);
         end else begin
            fail_count++;
            $display("packet %0d failed %0d checks", rec.pkt_num, wrong);
         end
      end
   endtask

   always @(negedge clk) begin
      if (out_wr) check_result();   // outputs settle well before the falling edge
   end

   // watchdog sized from the number of data lines
   initial begin
      int limit;
      wait (loaded);
      limit = (lines.size() + `OP_LUT_LATENCY + 20) * CLK_PERIOD;
      #(limit);
      $display("timeout: the run did not finish within %0d ns", limit);
      $display("Errors found");
      $finish;
   end

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      reset       = 1'b1;
      in_wr       = 1'b0;
      in_hdr      = '0;
      port_macs   = '0;
      route_wr    = 1'b0;
      route_addr  = '0;
      route_entry = '0;
      if (!read_data_file()) begin
         $display("could not open tb/lookup_input.dat");
         $display("Errors found");
         $finish;
      end else begin
         loaded = 1'b1;
         repeat (2) @(posedge clk);
         #2 reset = 1'b0;
         foreach (lines[i]) begin
            @(posedge clk);
            #2 apply_line(lines[i]);
         end
         @(posedge clk);
         #2 in_wr = 1'b0;
         route_wr = 1'b0;
         while (exp_q.size() != 0) @(negedge clk);
         repeat (`OP_LUT_LATENCY + 2) @(negedge clk);   // catches late stray pulses
         $display("%0d tests: %0d passed, %0d failed, %0d stray outputs, %0d bad lines",
                  pkt_count, pass_count, fail_count, stray_count, bad_lines);
         if (pkt_count > 0 && pass_count == pkt_count && fail_count == 0 &&
             stray_count == 0 && bad_lines == 0) begin
            $display("No errors");
         end else begin
            $display("Errors found");
         end
         $finish;
      end
   end

endmodule

/* rtl/output_port_lookup.sv */
`include "op_lut_consts.svh"

module output_port_lookup (
   input  logic                                             clk,
   input  logic                                             reset,
   input  logic                                             in_wr,
   input  net_hdr_pkg::pkt_hdr_t                            in_hdr,
   input  net_hdr_pkg::mac_addr_t [`OP_LUT_NUM_PORTS-1:0]  port_macs,
   input  logic                                             route_wr,
   input  logic [`OP_LUT_ROUTE_ADDR_BITS-1:0]              route_addr,
   input  op_lut_pkg::route_entry_t                         route_entry,
   output logic                                             out_wr,
   output op_lut_pkg::decision_t                            out_dec
);

   import op_lut_pkg::*;

   cls_rec_t cls;   // stage 1 to 2
   lpm_rec_t lpm;   // stage 2 to 3
   ttl_rec_t ttl;   // stage 3 to 4

   eth_classify eth_classify (
      .clk         (clk),
      .reset       (reset),
      .in_wr       (in_wr),
      .in_hdr      (in_hdr),
      .port_macs   (port_macs),
      .cls         (cls)
   );

   ip_lpm ip_lpm (
      .clk         (clk),
      .reset       (reset),
      .cls         (cls),
      .route_wr    (route_wr),
      .route_addr  (route_addr),
      .route_entry (route_entry),
      .lpm         (lpm)
   );

   ip_checksum_ttl ip_checksum_ttl (
      .clk         (clk),
      .reset       (reset),
      .lpm         (lpm),
      .ttl         (ttl)
   );

   op_lut_decide op_lut_decide (
      .clk         (clk),
      .reset       (reset),
      .ttl         (ttl),
      .out_wr      (out_wr),
      .out_dec     (out_dec)
   );

endmodule

/* rtl/op_lut_decide.sv */
`include "op_lut_consts.svh"

module op_lut_decide (
   input  logic                  clk,
   input  logic                  reset,
   input  op_lut_pkg::ttl_rec_t  ttl,
   output logic                  out_wr,
   output op_lut_pkg::decision_t out_dec
);

   import op_lut_pkg::*;

   cls_rec_t                      cls;
   logic [`OP_LUT_QUEUE_BITS-1:0] cpu_idx;
   logic [`OP_LUT_NUM_QUEUES-1:0] cpu_queue;
   action_e                       action;
   logic [`OP_LUT_NUM_QUEUES-1:0] queue;

   assign cls = ttl.lpm.cls;

   // each MAC port has its CPU queue right above it
   assign cpu_idx = {cls.hdr.in_port, 1'b1};

   always_comb begin
      cpu_queue          = '0;
      cpu_queue[cpu_idx] = 1'b1;
   end

   //////////////////////////////////////////////////////////////////////
   // action from the first rule that applies
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      if (!cls.mac_ok && !cls.is_bcast) begin
         action = DROP;          // not addressed to us
         queue  = '0;
      end else if (cls.is_bcast || !cls.is_ip || !cls.hdr_ok) begin
         action = TO_CPU;        // non-IP, broadcast or options
         queue  = cpu_queue;
      end else if (!ttl.checksum_ok) begin
         action = DROP;
         queue  = '0;
      end else if (!ttl.ttl_ok || !ttl.lpm.lpm_hit) begin
         action = TO_CPU;        // expiring TTL or no route
         queue  = cpu_queue;
      end else begin
         action = FORWARD;
         queue  = ttl.lpm.lpm_queue;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stage 4 register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         out_wr <= 1'b0;
      end else begin
         out_wr <= cls.valid;
      end
   end

   always_ff @(posedge clk) begin
      out_dec.action       <= action;
      out_dec.queue        <= queue;
      out_dec.in_port      <= `OP_LUT_QUEUE_BITS'(cls.hdr.in_port);
      out_dec.new_ttl      <= ttl.new_ttl;
      out_dec.new_checksum <= ttl.new_checksum;
   end

endmodule

/* rtl/ip_checksum_ttl.sv */
module ip_checksum_ttl (
   input  logic                 clk,
   input  logic                 reset,
   input  op_lut_pkg::lpm_rec_t lpm,
   output op_lut_pkg::ttl_rec_t ttl
);

   logic [9:0][15:0] hdr_words;   // the IPv4 header as ten 16 bit words
   logic [19:0]      word_sum;    // wide enough for ten words
   logic [16:0]      fold_1;
   logic [15:0]      fold_2;
   logic             checksum_ok;

   logic [7:0]       old_ttl;
   logic             ttl_ok;
   logic [7:0]       new_ttl;
   logic [16:0]      csum_inc;
   logic [15:0]      new_checksum;

   //////////////////////////////////////////////////////////////////////
   // header checksum check
   //////////////////////////////////////////////////////////////////////

   assign hdr_words = lpm.cls.hdr.ip;

   always_comb begin
      word_sum = '0;
      for (int i = 0; i < 10; i++) begin
         word_sum = word_sum + 20'(hdr_words[i]);
      end
   end

   // two folds are enough to bring the carries back in
   assign fold_1 = {1'b0, word_sum[15:0]} + 17'(word_sum[19:16]);
   assign fold_2 = fold_1[15:0] + 16'(fold_1[16]);

   // a good header sums to all ones
   assign checksum_ok = (fold_2 == 16'hffff);

   //////////////////////////////////////////////////////////////////////
   // TTL and incremental checksum update
   //////////////////////////////////////////////////////////////////////

   assign old_ttl = lpm.cls.hdr.ip.ttl;
   assign ttl_ok  = (old_ttl > 8'd1);
   assign new_ttl = old_ttl - 8'd1;

   // TTL is the high byte of its word, so the checksum moves by 0x0100
   assign csum_inc     = {1'b0, lpm.cls.hdr.ip.checksum} + 17'h0_0100;
   assign new_checksum = csum_inc[15:0] + 16'(csum_inc[16]);   // end-around carry

   //////////////////////////////////////////////////////////////////////
   // stage 3 register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      ttl.lpm          <= lpm;
      ttl.checksum_ok  <= checksum_ok;
      ttl.ttl_ok       <= ttl_ok;
      ttl.new_ttl      <= new_ttl;
      ttl.new_checksum <= new_checksum;
      if (reset) begin
         ttl.lpm.cls.valid <= 1'b0;
      end
   end

endmodule

/* rtl/ip_lpm.sv */
`include "op_lut_consts.svh"

module ip_lpm (
   input  logic                                clk,
   input  logic                                reset,
   input  op_lut_pkg::cls_rec_t                cls,
   input  logic                                route_wr,
   input  logic [`OP_LUT_ROUTE_ADDR_BITS-1:0]  route_addr,
   input  op_lut_pkg::route_entry_t            route_entry,
   output op_lut_pkg::lpm_rec_t                lpm
);

   import net_hdr_pkg::*;

   localparam int DEPTH = `OP_LUT_ROUTE_DEPTH;

   // route table storage
   logic [DEPTH-1:0]              route_vld;
   ip_addr_t                      route_ip    [DEPTH];
   ip_addr_t                      route_mask  [DEPTH];
   logic [`OP_LUT_NUM_QUEUES-1:0] route_queue [DEPTH];

   ip_addr_t                      dst_ip;
   logic [DEPTH-1:0]              match;
   logic                          lpm_hit;
   logic [`OP_LUT_NUM_QUEUES-1:0] lpm_queue;

   //////////////////////////////////////////////////////////////////////
   // write port
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         route_vld <= '0;
      end else if (route_wr) begin
         route_vld[route_addr] <= route_entry.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (route_wr) begin
         route_ip[route_addr]    <= route_entry.ip;
         route_mask[route_addr]  <= route_entry.mask;
         route_queue[route_addr] <= route_entry.queue;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // match against every entry at once
   //////////////////////////////////////////////////////////////////////

   assign dst_ip = cls.hdr.ip.dst_ip;

   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         match[i] = route_vld[i] &&
                    ((dst_ip & route_mask[i]) == (route_ip[i] & route_mask[i]));
      end
   end

   // lowest index wins since longer prefixes sit at low addresses
   always_comb begin
      lpm_hit   = 1'b0;
      lpm_queue = '0;
      for (int i = DEPTH - 1; i >= 0; i--) begin
         if (match[i]) begin
            lpm_hit   = 1'b1;
            lpm_queue = route_queue[i];
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stage 2 register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      lpm.cls       <= cls;
      lpm.lpm_hit   <= lpm_hit;
      lpm.lpm_queue <= lpm_queue;
      if (reset) begin
         lpm.cls.valid <= 1'b0;
      end
   end

endmodule

/* rtl/eth_classify.sv */
`include "op_lut_consts.svh"

module eth_classify (
   input  logic                                             clk,
   input  logic                                             reset,
   input  logic                                             in_wr,
   input  net_hdr_pkg::pkt_hdr_t                            in_hdr,
   input  net_hdr_pkg::mac_addr_t [`OP_LUT_NUM_PORTS-1:0]  port_macs,
   output op_lut_pkg::cls_rec_t                             cls
);

   import net_hdr_pkg::*;

   mac_addr_t my_mac;     // MAC of the port the header came in on
   logic      mac_ok;
   logic      is_bcast;
   logic      is_ip;
   logic      hdr_ok;

   //////////////////////////////////////////////////////////////////////
   // ethernet checks
   //////////////////////////////////////////////////////////////////////

   assign my_mac   = port_macs[in_hdr.in_port];
   assign mac_ok   = (in_hdr.eth.dst_mac == my_mac);
   assign is_bcast = (in_hdr.eth.dst_mac == `OP_LUT_BCAST_MAC);

   assign is_ip    = (in_hdr.eth.ethertype == ETHERTYPE_IPV4);

   // anything with options goes to software
   assign hdr_ok   = (in_hdr.ip.version == `OP_LUT_IP_VERSION) &&
                     (in_hdr.ip.ihl == `OP_LUT_IP_IHL);

   //////////////////////////////////////////////////////////////////////
   // stage 1 register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      cls.valid    <= in_wr;
      cls.hdr      <= in_hdr;
      cls.mac_ok   <= mac_ok;
      cls.is_bcast <= is_bcast;
      cls.is_ip    <= is_ip;
      cls.hdr_ok   <= hdr_ok;
      if (reset) begin
         cls.valid <= 1'b0;
      end
   end

endmodule

/* rtl/op_lut_pkg.sv */
`include "op_lut_consts.svh"

package op_lut_pkg;

   typedef enum logic [1:0] {
      FORWARD = 2'd0,
      TO_CPU  = 2'd1,
      DROP    = 2'd2
   } action_e;

   // one line of the route table
   typedef struct packed {
      logic                          valid;
      net_hdr_pkg::ip_addr_t         ip;
      net_hdr_pkg::ip_addr_t         mask;
      logic [`OP_LUT_NUM_QUEUES-1:0] queue;   // one-hot
   } route_entry_t;

   //////////////////////////////////////////////////////////////////////
   // pipeline records where each stage wraps the one before it
   //////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic                  valid;
      net_hdr_pkg::pkt_hdr_t hdr;
      logic                  mac_ok;     // dst MAC is the input port's MAC
      logic                  is_bcast;
      logic                  is_ip;
      logic                  hdr_ok;     // version 4 without options
   } cls_rec_t;

   typedef struct packed {
      cls_rec_t                      cls;
      logic                          lpm_hit;
      logic [`OP_LUT_NUM_QUEUES-1:0] lpm_queue;
   } lpm_rec_t;

   typedef struct packed {
      lpm_rec_t    lpm;
      logic        checksum_ok;
      logic        ttl_ok;
      logic [7:0]  new_ttl;
      logic [15:0] new_checksum;
   } ttl_rec_t;

   // what leaves the lookup
   typedef struct packed {
      action_e                       action;
      logic [`OP_LUT_NUM_QUEUES-1:0] queue;     // one-hot and zero on drop
      logic [`OP_LUT_QUEUE_BITS-1:0] in_port;   // zero extended
      logic [7:0]                    new_ttl;
      logic [15:0]                   new_checksum;
   } decision_t;

endpackage

/* rtl/net_hdr_pkg.sv */
`include "op_lut_consts.svh"

package net_hdr_pkg;

   typedef logic [47:0] mac_addr_t;
   typedef logic [31:0] ip_addr_t;

   // only the ethertypes the lookup cares about
   typedef enum logic [15:0] {
      ETHERTYPE_IPV4 = 16'h0800,
      ETHERTYPE_ARP  = 16'h0806
   } ethertype_e;

   typedef struct packed {
      mac_addr_t  dst_mac;
      mac_addr_t  src_mac;
      ethertype_e ethertype;
   } eth_hdr_t;

   //////////////////////////////////////////////////////////////////////
   // IPv4 header with the first word in the top bits
   //////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [3:0]  version;
      logic [3:0]  ihl;          // in 32 bit words
      logic [7:0]  tos;
      logic [15:0] length;
      logic [15:0] id;
      logic [15:0] flags_frag;
      logic [7:0]  ttl;
      logic [7:0]  protocol;
      logic [15:0] checksum;
      ip_addr_t    src_ip;
      ip_addr_t    dst_ip;
   } ipv4_hdr_t;

   // one parsed header as it enters the lookup
   typedef struct packed {
      logic [`OP_LUT_PORT_BITS-1:0] in_port;
      eth_hdr_t                     eth;
      ipv4_hdr_t                    ip;
   } pkt_hdr_t;

endpackage

/* rtl/op_lut_consts.svh */
`ifndef OP_LUT_CONSTS_SVH
`define OP_LUT_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// ports and output queues
//////////////////////////////////////////////////////////////////////

`define OP_LUT_NUM_PORTS        4      // MAC ports
`define OP_LUT_NUM_QUEUES       8      // even queues go to MACs and odd ones to the CPU
`define OP_LUT_QUEUE_BITS       3
`define OP_LUT_PORT_BITS        2

// route table
`define OP_LUT_ROUTE_DEPTH      8
`define OP_LUT_ROUTE_ADDR_BITS  3

// strobe in to strobe out
`define OP_LUT_LATENCY          4

//////////////////////////////////////////////////////////////////////
// special values
//////////////////////////////////////////////////////////////////////

`define OP_LUT_BCAST_MAC        48'hffff_ffff_ffff
`define OP_LUT_IP_VERSION       4'd4
`define OP_LUT_IP_IHL           4'd5   // 20 byte header without options

`endif
